// File: rtl/permuteConsts.svh
`ifndef PERMUTE_CONSTS_SVH
`define PERMUTE_CONSTS_SVH

// functions of seven variables
`define PERM_VAR_COUNT 7

// one truth-table bit per input assignment
`define PERM_TABLE_BITS (1 << `PERM_VAR_COUNT)

// 4! orderings of variables 3..6
`define PERM_RESULT_BITS 24

`endif

// File: rtl/permutePkg.sv
`include "permuteConsts.svh"

package permutePkg;

    // bit i is the function value at assignment i, bit k of i is variable k
    typedef logic [`PERM_TABLE_BITS-1:0] truthTable;

    // msb first: ABCD ABDC ACBD ACDB ADBC ADCB, then the B, C and D groups
    typedef logic [`PERM_RESULT_BITS-1:0] permMask;

    typedef struct packed {
        truthTable top; // upper half
        truthTable bot;
    } tablePair;

endpackage

// File: rtl/varSwap.sv
`include "permuteConsts.svh"

// exchanges variables varA and varB of a truth table
module varSwap #(
    parameter int varA = 3,
    parameter int varB = 4
) (
    input  permutePkg::truthTable tableIn,
    output permutePkg::truthTable tableOut
);

    localparam int swapBits = (1 << varA) | (1 << varB);

    for (genvar i = 0; i < `PERM_TABLE_BITS; i++) begin : gBit
        localparam int bitA = (i >> varA) & 1;
        localparam int bitB = (i >> varB) & 1;
        // same assignment with the two variable values traded
        localparam int srcIdx = (i & ~swapBits) | (bitA << varB) | (bitB << varA);

        assign tableOut[i] = tableIn[srcIdx];
    end

endmodule

// File: rtl/permuteCheck2.sv
// checks bot and its 5/6 swapped form against top
module permuteCheck2 (
    input  permutePkg::truthTable top,
    input  permutePkg::truthTable bot,
    output logic [1:0]            below
);

    permutePkg::truthTable botSwap56;

    varSwap #(
        .varA (5),
        .varB (6)
    ) swap56 (
        .tableIn  (bot),
        .tableOut (botSwap56)
    );

    // below when no bit is 1 in bot and 0 in top
    assign below[1] = ~|(bot & ~top);       // bot as given
    assign below[0] = ~|(botSwap56 & ~top); // variables 5 and 6 traded

endmodule

// File: rtl/permuteCheck24.sv
// all 24 orderings of variables 3..6 (A..D) of bot, each tested below top
module permuteCheck24 (
    input  permutePkg::truthTable top,
    input  permutePkg::truthTable bot,
    output permutePkg::permMask   validMask
);

    permutePkg::truthTable botBACD, botCBAD, botDBCA;
    permutePkg::truthTable botACBD, botBCAD, botCABD, botDCBA;
    permutePkg::truthTable botADCB, botBDCA, botCDAB, botDACB;

    logic [1:0] fromABCD, fromBACD, fromCBAD, fromDBCA;
    logic [1:0] fromACBD, fromBCAD, fromCABD, fromDCBA;
    logic [1:0] fromADCB, fromBDCA, fromCDAB, fromDACB;

    // base tables, one per choice of the leading variable
    varSwap #(.varA(3), .varB(4)) swap34 (.tableIn(bot), .tableOut(botBACD));
    varSwap #(.varA(3), .varB(5)) swap35 (.tableIn(bot), .tableOut(botCBAD));
    varSwap #(.varA(3), .varB(6)) swap36 (.tableIn(bot), .tableOut(botDBCA));

    // 4/5 swap of each base table
    varSwap #(.varA(4), .varB(5)) swap33x45 (.tableIn(bot),     .tableOut(botACBD));
    varSwap #(.varA(4), .varB(5)) swap34x45 (.tableIn(botBACD), .tableOut(botBCAD));
    varSwap #(.varA(4), .varB(5)) swap35x45 (.tableIn(botCBAD), .tableOut(botCABD));
    varSwap #(.varA(4), .varB(5)) swap36x45 (.tableIn(botDBCA), .tableOut(botDCBA));

    // 4/6 swap of each base table
    varSwap #(.varA(4), .varB(6)) swap33x46 (.tableIn(bot),     .tableOut(botADCB));
    varSwap #(.varA(4), .varB(6)) swap34x46 (.tableIn(botBACD), .tableOut(botBDCA));
    varSwap #(.varA(4), .varB(6)) swap35x46 (.tableIn(botCBAD), .tableOut(botCDAB));
    varSwap #(.varA(4), .varB(6)) swap36x46 (.tableIn(botDBCA), .tableOut(botDACB));

    // each checker also covers the 5/6 swap of its table
    permuteCheck2 checkABCD (.top(top), .bot(bot),     .below(fromABCD)); // ABCD, ABDC
    permuteCheck2 checkBACD (.top(top), .bot(botBACD), .below(fromBACD)); // BACD, BADC
    permuteCheck2 checkCBAD (.top(top), .bot(botCBAD), .below(fromCBAD)); // CBAD, CBDA
    permuteCheck2 checkDBCA (.top(top), .bot(botDBCA), .below(fromDBCA)); // DBCA, DBAC

    permuteCheck2 checkACBD (.top(top), .bot(botACBD), .below(fromACBD)); // ACBD, ACDB
    permuteCheck2 checkBCAD (.top(top), .bot(botBCAD), .below(fromBCAD)); // BCAD, BCDA
    permuteCheck2 checkCABD (.top(top), .bot(botCABD), .below(fromCABD)); // CABD, CADB
    permuteCheck2 checkDCBA (.top(top), .bot(botDCBA), .below(fromDCBA)); // DCBA, DCAB

    permuteCheck2 checkADCB (.top(top), .bot(botADCB), .below(fromADCB)); // ADCB, ADBC
    permuteCheck2 checkBDCA (.top(top), .bot(botBDCA), .below(fromBDCA)); // BDCA, BDAC
    permuteCheck2 checkCDAB (.top(top), .bot(botCDAB), .below(fromCDAB)); // CDAB, CDBA
    permuteCheck2 checkDACB (.top(top), .bot(botDACB), .below(fromDACB)); // DACB, DABC

    // the 4/6 checkers report in reverse order within their group
    assign validMask = {
        fromABCD, fromACBD, fromADCB[0], fromADCB[1], // group A
        fromBACD, fromBCAD, fromBDCA[0], fromBDCA[1], // group B
        fromCBAD, fromCABD, fromCDAB[0], fromCDAB[1], // group C
        fromDBCA, fromDCBA, fromDACB[0], fromDACB[1]  // group D
    };

endmodule

// File: rtl/fourPhaseStage.sv
// one-entry register stage, four-phase req/ack upstream and downstream
module fourPhaseStage #(
    parameter type payloadType = logic
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       upReq,
    output logic       upAck,
    input  payloadType upData,
    output logic       downReq,
    input  logic       downAck,
    output payloadType downData
);

    logic       full;
    payloadType dataQ;

    logic capture;

    // new item only once the previous upstream cycle has fully closed
    assign capture = !full && upReq && !upAck;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            full    <= 1'b0;
            upAck   <= 1'b0;
            downReq <= 1'b0;
        end else begin
            if (capture) begin
                full    <= 1'b1;
                upAck   <= 1'b1;
                downReq <= 1'b1;
            end else begin
                if (upAck && !upReq) begin
                    upAck <= 1'b0; // upstream return to zero
                end
                if (downReq && downAck) begin
                    downReq <= 1'b0;
                end
                if (full && !downReq && !downAck) begin
                    full <= 1'b0; // downstream cycle closed
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dataQ <= upData;
        end
    end

    assign downData = dataQ;

    // receiver may sample downData any time while req is up
    assertDownStable: assert property (@(posedge clk) disable iff (!arstN)
        $past(downReq) && downReq |-> $stable(downData))
        else $error("downData changed while downReq high");

    assertAckAfterReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(upAck) |-> $past(upReq))
        else $error("upAck rose without upReq");

endmodule

// File: rtl/permuteCheckTop.sv
// input stage -> 24-way permutation check -> result stage
module permuteCheckTop (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inReq,
    output logic                  inAck,
    input  permutePkg::truthTable inTop,
    input  permutePkg::truthTable inBot,
    output logic                  outReq,
    input  logic                  outAck,
    output permutePkg::permMask   outMask
);

    permutePkg::tablePair pairIn;
    permutePkg::tablePair pairHeld;
    permutePkg::permMask  maskComb;

    logic midReq;
    logic midAck;

    assign pairIn = {inTop, inBot}; // top in the upper half

    fourPhaseStage #(
        .payloadType (permutePkg::tablePair)
    ) inStage (
        .clk      (clk),
        .arstN    (arstN),
        .upReq    (inReq),
        .upAck    (inAck),
        .upData   (pairIn),
        .downReq  (midReq),
        .downAck  (midAck),
        .downData (pairHeld)
    );

    // pairHeld stays put while midReq is high, so the mask is settled
    permuteCheck24 check (
        .top       (pairHeld.top),
        .bot       (pairHeld.bot),
        .validMask (maskComb)
    );

    fourPhaseStage #(
        .payloadType (permutePkg::permMask)
    ) outStage (
        .clk      (clk),
        .arstN    (arstN),
        .upReq    (midReq),
        .upAck    (midAck),
        .upData   (maskComb),
        .downReq  (outReq),
        .downAck  (outAck),
        .downData (outMask)
    );

    // sender must hold the pair until the subsystem acknowledges it
    assertInStable: assert property (@(posedge clk) disable iff (!arstN)
        $past(inReq && !inAck) && inReq |-> $stable({inTop, inBot}))
        else $error("inTop/inBot changed before inAck");

endmodule

// File: sim/permuteCheckTb.sv
`include "permuteConsts.svh"

module permuteCheckTb;

    localparam int caseCount    = 30;
    localparam int wordsPerCase = 3;   // top, bot, expected mask
    localparam int ackTimeout   = 50;
    localparam int reqTimeout   = 400; // a result can sit behind back-pressure

    logic                  clk;
    logic                  arstN;
    logic                  inReq;
    logic                  inAck;
    permutePkg::truthTable inTop;
    permutePkg::truthTable inBot;
    logic                  outReq;
    logic                  outAck;
    permutePkg::permMask   outMask;

    permutePkg::truthTable caseMem [0:caseCount*wordsPerCase-1];
    permutePkg::permMask   expectQ [$]; // masks of pairs sent, oldest first
    int                    received;

    logic lastInReq;
    logic lastInAck;
    logic lastOutReq;
    logic lastOutAck;

    permuteCheckTop u_permuteCheckTop (
        .clk     (clk),
        .arstN   (arstN),
        .inReq   (inReq),
        .inAck   (inAck),
        .inTop   (inTop),
        .inBot   (inBot),
        .outReq  (outReq),
        .outAck  (outAck),
        .outMask (outMask)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stopRun();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input permutePkg::truthTable got,
                              input permutePkg::truthTable expected);
        if (got !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected);
            stopRun();
        end
    endtask

    task automatic sendCases();
        int waitCount;
        for (int n = 0; n < caseCount; n++) begin
            expectQ.push_back(caseMem[n*wordsPerCase+2][`PERM_RESULT_BITS-1:0]);
            inTop <= caseMem[n*wordsPerCase];
            inBot <= caseMem[n*wordsPerCase+1];
            inReq <= 1'b1;
            waitCount = 0;
            @(posedge clk);
            while (!inAck) begin
                waitCount++;
                if (waitCount > ackTimeout) begin
                    $display("timeout: inAck did not rise for case %0d", n);
                    stopRun();
                end
                @(posedge clk);
            end
            inReq <= 1'b0; // data stays put, only req drops
            waitCount = 0;
            @(posedge clk);
            while (inAck) begin
                waitCount++;
                if (waitCount > ackTimeout) begin
                    $display("timeout: inAck did not fall for case %0d", n);
                    stopRun();
                end
                @(posedge clk);
            end
        end
    endtask

    task automatic receiveResults();
        int                  waitCount;
        int                  delay;
        permutePkg::permMask expected;
        while (received < caseCount) begin
            waitCount = 0;
            @(posedge clk);
            while (!outReq) begin
                waitCount++;
                if (waitCount > reqTimeout) begin
                    $display("timeout: no outReq for result %0d", received);
                    stopRun();
                end
                @(posedge clk);
            end
            delay = $urandom_range(7, 0);
            repeat (delay) @(posedge clk);
            if (expectQ.size() == 0) begin
                $display("outReq was raised with no pair outstanding");
                stopRun();
            end
            expected = expectQ.pop_front();
            checkValue($sformatf("outMask of case %0d", received),
                       permutePkg::truthTable'(outMask), permutePkg::truthTable'(expected));
            outAck <= 1'b1;
            waitCount = 0;
            @(posedge clk);
            while (outReq) begin
                waitCount++;
                if (waitCount > ackTimeout) begin
                    $display("timeout: outReq did not fall for result %0d", received);
                    stopRun();
                end
                @(posedge clk);
            end
            outAck <= 1'b0;
            received++;
        end
    endtask

    // four-phase order on both ports, seen from outside the DUT
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lastInReq  <= 1'b0;
            lastInAck  <= 1'b0;
            lastOutReq <= 1'b0;
            lastOutAck <= 1'b0;
        end else begin
            if (inAck && !lastInAck && !lastInReq) begin
                $display("handshake broken: inAck rose while inReq was low");
                stopRun();
            end
            if (!inAck && lastInAck && lastInReq) begin
                $display("handshake broken: inAck fell while inReq was still high");
                stopRun();
            end
            if (outReq && !lastOutReq && lastOutAck) begin
                $display("handshake broken: outReq rose while outAck was still high");
                stopRun();
            end
            if (!outReq && lastOutReq && !lastOutAck) begin
                $display("handshake broken: outReq fell before outAck was raised");
                stopRun();
            end
            lastInReq  <= inReq;
            lastInAck  <= inAck;
            lastOutReq <= outReq;
            lastOutAck <= outAck;
        end
    end

    initial begin
        arstN    = 1'b0;
        inReq    = 1'b0;
        inTop    = '0;
        inBot    = '0;
        outAck   = 1'b0;
        received = 0;
        void'($urandom(32'h18d1_70cb));
        // upper bits set, so a missing line shows up as a bad mask word
        for (int i = 0; i < caseCount*wordsPerCase; i++) begin
            caseMem[i] = {4{~32'(i)}};
        end
        $readmemh("sim/permuteCases.mem", caseMem);
        for (int n = 0; n < caseCount; n++) begin
            if (caseMem[n*wordsPerCase+2][`PERM_TABLE_BITS-1:`PERM_RESULT_BITS] != '0) begin
                $display("case file has a missing or malformed line at case %0d", n);
                stopRun();
            end
        end
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        checkValue("inAck after reset", permutePkg::truthTable'(inAck), '0);
        checkValue("outReq after reset", permutePkg::truthTable'(outReq), '0);
        fork
            sendCases();
            receiveResults();
        join
        if (received == caseCount && expectQ.size() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("run ended with %0d of %0d results received", received, caseCount);
            stopRun();
        end
    end

endmodule

// File: project.f
+incdir+rtl
rtl/permutePkg.sv
rtl/varSwap.sv
rtl/permuteCheck2.sv
rtl/permuteCheck24.sv
rtl/fourPhaseStage.sv
rtl/permuteCheckTop.sv
sim/permuteCheckTb.sv

// File: run.sh
#!/bin/sh
# compile and run the permuteCheck testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module permuteCheckTb -o permuteCheckSim > build.log 2>&1 \
    && ./obj_dir/permuteCheckSim > sim.log 2>&1 \
    || echo "build or simulation returned an error, see build.log and sim.log"

grep -qx "Finished with no errors" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

// File: sim/permuteCases.mem
// columns: top, bot, expected mask (hex); mask bit 23 is ABCD, bit 0 is DACB
// A..D are variables 3..6, one case per line
00000000000000000000000000000000 00000000000000000000000000000000 FFFFFF
0123456789ABCDEFFEDCBA9876543210 00000000000000000000000000000000 FFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 00000000000000000000000000000000 FFFFFF
00000000000000000000000000000000 FF00FF00FF00FF00FF00FF00FF00FF00 000000
00000000000000000000000000000000 00000000000000000000000000000001 000000
00000000000000000000000000000000 DEADBEEF0BADF00D13579BDF2468ACE0 000000
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 0123456789ABCDEFFEDCBA9876543210 FFFFFF
FF000000000000000000000000000000 FF000000000000000000000000000000 FFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF00 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF00 FFFFFF
00FFFF00FF0000FFFF0000FF00FFFF00 00FFFF00FF0000FFFF0000FF00FFFF00 FFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFF00 FFFFFFFFFFFFFFFF0000000000000000 FFFFFF
FF00FF00FF00FF00FF00FF00FF00FF00 FF00FF00FF00FF00FF00FF00FF00FF00 FC0000
FFFF0000FFFF0000FFFF0000FFFF0000 FF00FF00FF00FF00FF00FF00FF00FF00 030303
FFFFFFFF00000000FFFFFFFF00000000 FF00FF00FF00FF00FF00FF00FF00FF00 00A854
FFFFFFFFFFFFFFFF0000000000000000 FF00FF00FF00FF00FF00FF00FF00FF00 0054A8
FF00FF00FF00FF00FF00FF00FF00FF00 FFFF0000FFFF0000FFFF0000FFFF0000 03F000
FF00FF00FF00FF00FF00FF00FF00FF00 FFFFFFFF00000000FFFFFFFF00000000 000FC0
FF00FF00FF00FF00FF00FF00FF00FF00 FFFFFFFFFFFFFFFF0000000000000000 00003F
FF000000FF000000FF000000FF000000 FF000000FF000000FF000000FF000000 C30000
0000FF000000FF000000FF000000FF00 0000FF000000FF000000FF000000FF00 C00000
FFFFFFFFFFFFFFFFFFFFFFFF00000000 FF000000FF000000FF000000FF000000 3CFFFF
00000000FFFF000000000000FFFF0000 0000000000000000FF00FF00FF00FF00 010100
FFFFFFFFFFFFFFFFFF00FF00FF00FF00 FF00FF00FF00FF00FF00FF00FF00FF00 FC54A8
FFFFFFFFFFFFFFFF0000000000000000 FF00000000000000FF00000000000000 5D75FF
00000000FFFFFFFF00000000FFFFFFFF 0000FFFF0000FFFF0000FFFF0000FFFF 28028A
FFFF0000FFFF00000000000000000000 FFFF0000FFFF00000000000000000000 840840
0000000000000000FFFFFFFF00000000 0000000000000000FFFFFFFF00000000 820000
FF00FF00FF00FF00FF00FF00FF00FF00 AA00AA00AA00AA00AA00AA00AA00AA00 FC0000
AA00AA00AA00AA00AA00AA00AA00AA00 FF00FF00FF00FF00FF00FF00FF00FF00 000000
F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0F0 F0F0F0F000000000F0F0F0F000000000 FFFFFF
